/* csr_file.sv */
`timescale 1ns/1ps

module csr_file import rv_core_pkg::*; (
	input  logic            clk,
	input  logic            arst_n,
	input  csr_addr_t       addr,
	input  logic            we,
	input  logic [XLEN-1:0] wdata,
	output logic [XLEN-1:0] rdata
);

	logic [XLEN-1:0] mstatus;
	logic [XLEN-1:0] mtvec;
	logic [XLEN-1:0] mepc;
	logic [XLEN-1:0] mscratch;

	always_comb begin
		case (addr)
			CSR_MSTATUS:  rdata = mstatus;
			CSR_MTVEC:    rdata = mtvec;
			CSR_MEPC:     rdata = mepc;
			CSR_MSCRATCH: rdata = mscratch;
			default:      rdata = '0; // unimplemented CSR
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mstatus  <= '0;
			mtvec    <= '0;
			mepc     <= '0;
			mscratch <= '0;
		end else if (we) begin
			case (addr)
				CSR_MSTATUS:  mstatus  <= wdata;
				CSR_MTVEC:    mtvec    <= wdata;
				CSR_MEPC:     mepc     <= wdata;
				CSR_MSCRATCH: mscratch <= wdata;
				default:      ; // write dropped
			endcase
		end
	end

endmodule

/* dec_if.sv */
`timescale 1ns/1ps

interface dec_if import rv_core_pkg::*; ();

	inst_class_t     cls;
	logic [4:0]      rs1;
	logic [4:0]      rs2;
	logic [4:0]      rd;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [XLEN-1:0] imm;      // already sign extended for the class
	csr_addr_t       csr_addr;

	modport producer (
		output cls, rs1, rs2, rd, funct3, funct7, imm, csr_addr
	);

	modport consumer (
		input cls, rs1, rs2, rd, funct3, funct7, imm, csr_addr
	);

endinterface

/* exu.sv */
`timescale 1ns/1ps

module exu import rv_core_pkg::*; (
	dec_if.consumer         dec,
	input  logic [XLEN-1:0] src1,
	input  logic [XLEN-1:0] src2,
	input  logic [XLEN-1:0] pc,
	input  logic [XLEN-1:0] csr_val,
	output logic [XLEN-1:0] val,
	output logic [XLEN-1:0] csr_wdata,
	output logic            jump_en,
	output logic [3:0]      wmask
);

	logic [XLEN-1:0] lopd;
	logic [XLEN-1:0] ropd;
	alu_op_t         alu_op;
	logic [4:0]      shamt;
	logic [XLEN-1:0] op_diff;
	logic            op_borrow;
	logic            op_less;
	logic [XLEN-1:0] cmp_diff;
	logic            cmp_borrow;
	logic            cmp_less;
	logic            cmp_ne;
	logic            br_take;
	logic            alu_cls;

	assign alu_cls = dec.cls[INST_ALUI] | dec.cls[INST_ALUR];

	// left operand
	always_comb begin
		if (alu_cls | dec.cls[INST_JALR] | dec.cls[INST_LOAD] | dec.cls[INST_STORE])
			lopd = src1;
		else if (dec.cls[INST_LUI])
			lopd = '0;
		else
			lopd = pc; // auipc, jal, branch target
	end

	assign ropd = dec.cls[INST_ALUR] ? src2 : dec.imm;

	always_comb begin
		alu_op = ALU_ADD; // address and target math
		if (alu_cls) begin
			case (dec.funct3)
				3'b000:  alu_op = (dec.cls[INST_ALUR] & dec.funct7[5]) ? ALU_SUB : ALU_ADD;
				3'b001:  alu_op = ALU_SLL;
				3'b010:  alu_op = ALU_LESS;
				3'b011:  alu_op = ALU_ULESS;
				3'b100:  alu_op = ALU_XOR;
				3'b101:  alu_op = dec.funct7[5] ? ALU_SRA : ALU_SRL;
				3'b110:  alu_op = ALU_OR;
				default: alu_op = ALU_AND;
			endcase
		end
	end

	assign shamt = ropd[4:0];
	assign {op_borrow, op_diff} = {1'b0, lopd} - {1'b0, ropd};
	// signed less from sign bits and the difference
	assign op_less = (lopd[31] & ~ropd[31]) | (~(lopd[31] ^ ropd[31]) & op_diff[31]);

	always_comb begin
		case (alu_op)
			ALU_ADD:   val = lopd + ropd;
			ALU_SUB:   val = op_diff;
			ALU_AND:   val = lopd & ropd;
			ALU_XOR:   val = lopd ^ ropd;
			ALU_OR:    val = lopd | ropd;
			ALU_SRL:   val = lopd >> shamt;
			ALU_SRA:   val = $unsigned($signed(lopd) >>> shamt);
			ALU_SLL:   val = lopd << shamt;
			ALU_LESS:  val = {{(XLEN-1){1'b0}}, op_less};
			ALU_ULESS: val = {{(XLEN-1){1'b0}}, op_borrow};
			default:   val = '0;
		endcase
	end

	// branch compare runs on the registers, not on the adder
	assign {cmp_borrow, cmp_diff} = {1'b0, src1} - {1'b0, src2};
	assign cmp_less = (src1[31] & ~src2[31]) | (~(src1[31] ^ src2[31]) & cmp_diff[31]);
	assign cmp_ne   = |cmp_diff;

	always_comb begin
		case (dec.funct3)
			3'b000:  br_take = ~cmp_ne;     // beq
			3'b001:  br_take = cmp_ne;      // bne
			3'b100:  br_take = cmp_less;    // blt
			3'b101:  br_take = ~cmp_less;   // bge
			3'b110:  br_take = cmp_borrow;  // bltu
			3'b111:  br_take = ~cmp_borrow; // bgeu
			default: br_take = 1'b0;
		endcase
	end

	assign jump_en = dec.cls[INST_JAL] | dec.cls[INST_JALR] | (dec.cls[INST_BRANCH] & br_take);

	always_comb begin
		case (dec.funct3[1:0])
			2'b00:   wmask = 4'h1; // sb
			2'b01:   wmask = 4'h3; // sh
			2'b10:   wmask = 4'hf; // sw
			default: wmask = 4'h0;
		endcase
	end

	always_comb begin
		case (dec.funct3)
			3'b001:  csr_wdata = src1;           // csrrw
			3'b010:  csr_wdata = src1 | csr_val; // csrrs
			default: csr_wdata = '0;
		endcase
	end

	always_comb begin
		a_no_mem_jump: assert final (!(jump_en && (dec.cls[INST_LOAD] || dec.cls[INST_STORE])))
			else $error("exu jump_en raised for a memory instruction");
	end

endmodule

/* idu.sv */
`timescale 1ns/1ps

module idu import rv_core_pkg::*; #(
	parameter int NUM_REGS = 32
) (
	input  logic [31:0] instr,
	dec_if.producer     dec
);

	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_ALUI   = 7'b0010011;
	localparam logic [6:0] OPC_ALUR   = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	logic [6:0]      opcode;
	inst_class_t     cls;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_s;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_j;
	logic [XLEN-1:0] imm;

	assign opcode = instr[6:0];

	always_comb begin
		cls = '0;
		case (opcode)
			OPC_LUI:    cls[INST_LUI]    = 1'b1;
			OPC_AUIPC:  cls[INST_AUIPC]  = 1'b1;
			OPC_JAL:    cls[INST_JAL]    = 1'b1;
			OPC_JALR:   cls[INST_JALR]   = 1'b1;
			OPC_BRANCH: cls[INST_BRANCH] = 1'b1;
			OPC_LOAD:   cls[INST_LOAD]   = 1'b1;
			OPC_STORE:  cls[INST_STORE]  = 1'b1;
			OPC_ALUI:   cls[INST_ALUI]   = 1'b1;
			OPC_ALUR:   cls[INST_ALUR]   = 1'b1;
			OPC_SYSTEM: cls[INST_CSR]    = 1'b1;
			default:    cls = '0; // unknown opcode runs as a no-op
		endcase
	end

	// immediate formats
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		if (cls[INST_LUI] | cls[INST_AUIPC])
			imm = imm_u;
		else if (cls[INST_JAL])
			imm = imm_j;
		else if (cls[INST_BRANCH])
			imm = imm_b;
		else if (cls[INST_STORE])
			imm = imm_s;
		else if (cls[INST_JALR] | cls[INST_LOAD] | cls[INST_ALUI] | cls[INST_CSR])
			imm = imm_i;
		else
			imm = '0;
	end

	assign dec.cls      = cls;
	assign dec.rs1      = instr[19:15];
	assign dec.rs2      = instr[24:20];
	assign dec.rd       = instr[11:7];
	assign dec.funct3   = instr[14:12];
	assign dec.funct7   = instr[31:25];
	assign dec.imm      = imm;
	assign dec.csr_addr = instr[31:20];

	// only fields that are really register indices are range checked
	always_comb begin
		a_cls_onehot: assert final ($onehot0(cls))
			else $error("idu class vector not one-hot: %b", cls);
		a_rs_range: assert final (
			(!(cls[INST_JALR] | cls[INST_BRANCH] | cls[INST_LOAD] | cls[INST_STORE] |
			cls[INST_ALUI] | cls[INST_ALUR] | cls[INST_CSR]) || instr[19:15] < NUM_REGS) &&
			(!(cls[INST_BRANCH] | cls[INST_STORE] | cls[INST_ALUR]) ||
			instr[24:20] < NUM_REGS))
			else $error("idu source register out of range");
		a_rd_range: assert final (
			(cls & ~(inst_class_t'(1) << INST_BRANCH | inst_class_t'(1) << INST_STORE)) == '0 ||
			instr[11:7] < NUM_REGS)
			else $error("idu rd out of range: %0d", instr[11:7]);
	end

endmodule

/* regfile.sv */
`timescale 1ns/1ps

module regfile import rv_core_pkg::*; #(
	parameter int NUM_REGS = 32
) (
	input  logic            clk,
	input  logic            arst_n,
	input  logic [4:0]      rs1,
	input  logic [4:0]      rs2,
	input  logic [4:0]      rd,
	input  logic            we,
	input  logic [XLEN-1:0] wdata,
	output logic [XLEN-1:0] rdata1,
	output logic [XLEN-1:0] rdata2
);

	localparam int IW = $clog2(NUM_REGS);

	logic [XLEN-1:0] regs [NUM_REGS];

	assign rdata1 = regs[rs1[IW-1:0]];
	assign rdata2 = regs[rs2[IW-1:0]];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (we && rd[IW-1:0] != '0) begin // x0 stays zero
			regs[rd[IW-1:0]] <= wdata;
		end
	end

	a_x0_zero: assert property (@(posedge clk) disable iff (!arst_n)
		(rs1 == 5'd0 |-> rdata1 == '0) and (rs2 == 5'd0 |-> rdata2 == '0))
		else $error("regfile x0 read nonzero");

endmodule

/* rv_core.sv */
`timescale 1ns/1ps

module rv_core import rv_core_pkg::*; #(
	parameter int              NUM_REGS = 32,
	parameter logic [XLEN-1:0] RESET_PC = 32'h0000_0000
) (
	input  logic            clk,
	input  logic            arst_n,
	output logic [XLEN-1:0] imem_addr,
	input  logic [XLEN-1:0] imem_rdata,
	output logic [XLEN-1:0] dmem_addr,
	output logic [XLEN-1:0] dmem_wdata,
	output logic [3:0]      dmem_wmask,
	output logic            dmem_we,
	input  logic [XLEN-1:0] dmem_rdata
);

	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] pc_next;
	logic [XLEN-1:0] jump_target;
	logic [XLEN-1:0] src1;
	logic [XLEN-1:0] src2;
	logic [XLEN-1:0] exu_val;
	logic [XLEN-1:0] csr_val;
	logic [XLEN-1:0] csr_wdata;
	logic [XLEN-1:0] wb_val;
	logic            jump_en;
	logic [3:0]      wmask;
	logic            rd_we;
	logic            csr_we;

	dec_if dec ();

	idu #(.NUM_REGS(NUM_REGS)) u_idu (
		.instr (imem_rdata),
		.dec   (dec)
	);

	exu u_exu (
		.dec       (dec),
		.src1      (src1),
		.src2      (src2),
		.pc        (pc),
		.csr_val   (csr_val),
		.val       (exu_val),
		.csr_wdata (csr_wdata),
		.jump_en   (jump_en),
		.wmask     (wmask)
	);

	regfile #(.NUM_REGS(NUM_REGS)) u_regfile (
		.clk    (clk),
		.arst_n (arst_n),
		.rs1    (dec.rs1),
		.rs2    (dec.rs2),
		.rd     (dec.rd),
		.we     (rd_we),
		.wdata  (wb_val),
		.rdata1 (src1),
		.rdata2 (src2)
	);

	csr_file u_csr_file (
		.clk    (clk),
		.arst_n (arst_n),
		.addr   (dec.csr_addr),
		.we     (csr_we),
		.wdata  (csr_wdata),
		.rdata  (csr_val)
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= RESET_PC;
		end else begin
			pc <= pc_next;
		end
	end

	assign pc_plus4    = pc + 32'd4;
	assign jump_target = {exu_val[XLEN-1:1], exu_val[0] & ~dec.cls[INST_JALR]}; // jalr clears bit 0
	assign pc_next     = jump_en ? jump_target : pc_plus4;
	assign imem_addr   = pc;

	always_comb begin
		if (dec.cls[INST_JAL] | dec.cls[INST_JALR])
			wb_val = pc_plus4; // link
		else if (dec.cls[INST_LOAD])
			wb_val = dmem_rdata;
		else if (dec.cls[INST_CSR])
			wb_val = csr_val; // old value
		else
			wb_val = exu_val;
	end

	assign rd_we = ~(dec.cls[INST_BRANCH] | dec.cls[INST_STORE]) & (|dec.cls);
	assign csr_we = dec.cls[INST_CSR] & (dec.funct3 == 3'b001 || dec.funct3 == 3'b010);

	assign dmem_addr  = exu_val;
	assign dmem_wdata = src2; // low lanes, not shifted
	assign dmem_wmask = wmask;
	assign dmem_we    = arst_n & dec.cls[INST_STORE]; // no store while in reset

	a_we_mask: assert property (@(posedge clk) disable iff (!arst_n)
		dmem_we |-> dmem_wmask != 4'h0)
		else $error("store with empty byte mask at pc %h", pc);

endmodule

/* rv_core_pkg.sv */
package rv_core_pkg;

	localparam int XLEN = 32; // data and address width

	// bit positions in the one-hot class vector
	localparam int INST_LUI    = 0;
	localparam int INST_AUIPC  = 1;
	localparam int INST_JAL    = 2;
	localparam int INST_JALR   = 3;
	localparam int INST_BRANCH = 4;
	localparam int INST_LOAD   = 5;
	localparam int INST_STORE  = 6;
	localparam int INST_ALUI   = 7;
	localparam int INST_ALUR   = 8;
	localparam int INST_CSR    = 9;

	localparam int NUM_CLASS = 10;

	// all zero means no-op
	typedef logic [NUM_CLASS-1:0] inst_class_t;

	typedef enum logic [3:0] {
		ALU_ADD   = 4'd0,
		ALU_SUB   = 4'd1,
		ALU_AND   = 4'd2,
		ALU_XOR   = 4'd3,
		ALU_OR    = 4'd4,
		ALU_SRL   = 4'd5,
		ALU_SRA   = 4'd6,
		ALU_SLL   = 4'd7,
		ALU_LESS  = 4'd8, // slt/slti
		ALU_ULESS = 4'd9  // sltu/sltiu
	} alu_op_t;

	typedef logic [11:0] csr_addr_t;

	// machine CSRs present in csr_file
	localparam csr_addr_t CSR_MSTATUS  = 12'h300;
	localparam csr_addr_t CSR_MTVEC    = 12'h305;
	localparam csr_addr_t CSR_MSCRATCH = 12'h340;
	localparam csr_addr_t CSR_MEPC     = 12'h341;

endpackage

/* rv_core_testdata.txt */
# p: program words from RESET_PC, d: addr word, g: name lo hi, e: addr data mask
# groups come before the expected stores they cover
p 40002023 12300093 ffb00113 800001b7  first store at RESET_PC, alu setup
p 00208233 40402223 402082b3 40502423  add sub
p 0f017313 40602623 0030e3b3 40702823  andi or
p 0020c433 40802a23 00409493 40902c23  xor slli
p 0041d513 40a02e23 4041d593 42b02023  srli srai
p 00112633 42c02223 001136b3 42d02423  slt sltu
p 00012717 42e02623 42302823 00208463  auipc lui, beq not taken
p 44402023 00108463 7e102823 00109463  beq taken, bne
p 44502223 00209463 7e102823 0020c463  bne, blt
p 44602423 00114463 7e102823 00115463  blt, bge
p 44702623 0020d463 7e102823 00116463  bge, bltu
p 44802823 0020e463 7e102823 0020f463  bltu, bgeu
p 44902a23 00117463 7e102823 008007ef  bgeu, jal
p 7e102823 48f02023 1e500813 000808e7  jal link, jalr
p 7e102823 49102223 20002903 21202623  jalr link, lw
p 20800223 20701223 20402423 20402983  sb sh sw lw
p 21302823 34009a73 34011af3 4d502023  csrrw mscratch
p 3000ab73 3004abf3 30002c73 4d702223  csrrs mstatus
p 4d802423 7c009673 7c002773 4cc02623  unknown csr
p 4ce02823 0000006f                    self loop
d 200 cafef00d
d 204 11223344
g reset  400 403
g alu    404 43f
g branch 440 47f
g jump   480 49f
g mem    200 21f
g csr    4c0 4df
e 400 00000000 f
e 404 0000011e f
e 408 00000128 f
e 40c 000000f0 f
e 410 80000123 f
e 414 fffffed8 f
e 418 00001230 f
e 41c 08000000 f
e 420 f8000000 f
e 424 00000001 f
e 428 00000000 f
e 42c 00012160 f
e 430 80000000 f
e 440 0000011e f
e 444 00000128 f
e 448 000000f0 f
e 44c 80000123 f
e 450 fffffed8 f
e 454 00001230 f
e 480 000001d0 f
e 484 000001e0 f
e 20c cafef00d f
e 204 fffffed8 1
e 204 80000123 3
e 208 0000011e f
e 210 11220123 f
e 4c0 00000123 f
e 4c4 00000123 f
e 4c8 00001333 f
e 4cc 00000000 f
e 4d0 00000000 f

/* src.f */
rv_core_pkg.sv
dec_if.sv
idu.sv
exu.sv
regfile.sv
csr_file.sv
rv_core.sv
tb_clk_gen.sv
tb_rv_core.sv

/* tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int PERIOD_NS  = 4,
	parameter int RST_CYCLES = 5
) (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		arst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#1 arst_n = 1'b1; // released just after the edge
	end

endmodule

/* tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

	localparam logic [31:0] RESET_PC   = 32'h0000_0100;
	localparam int          IMEM_WORDS = 256;
	localparam int          DMEM_WORDS = 1024;
	localparam int          MAX_CYCLES = 2000;

	logic        clk;
	logic        arst_n;
	logic [31:0] imem_addr;
	logic [31:0] imem_rdata;
	logic [31:0] dmem_addr;
	logic [31:0] dmem_wdata;
	logic [3:0]  dmem_wmask;
	logic        dmem_we;
	logic [31:0] dmem_rdata;

	logic [31:0] imem [IMEM_WORDS];
	logic [31:0] dmem [DMEM_WORDS];

	// expected stores and test groups
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [3:0]  exp_mask [$];
	int          exp_grp [$];
	string       grp_name [$];
	logic [31:0] grp_lo [$];
	logic [31:0] grp_hi [$];
	int          grp_fail [$];
	int          idx;
	int          passes;
	int          errors;
	int          live_cycles;

	tb_clk_gen #(.PERIOD_NS(4), .RST_CYCLES(5)) u_clk_gen (
		.clk    (clk),
		.arst_n (arst_n)
	);

	rv_core #(.NUM_REGS(32), .RESET_PC(RESET_PC)) dut_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.imem_addr  (imem_addr),
		.imem_rdata (imem_rdata),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_wmask (dmem_wmask),
		.dmem_we    (dmem_we),
		.dmem_rdata (dmem_rdata)
	);

	// both memories answer in the same cycle
	assign imem_rdata = ((imem_addr - RESET_PC) >> 2) < IMEM_WORDS ?
		imem[(imem_addr - RESET_PC) >> 2] : 32'h0;
	assign dmem_rdata = dmem[dmem_addr[11:2]];

	always @(posedge clk) begin
		if (arst_n && dmem_we) begin
			for (int k = 0; k < 4; k++)
				if (dmem_wmask[k])
					dmem[dmem_addr[11:2]][8*k +: 8] <= dmem_wdata[8*k +: 8];
		end
	end

	task automatic load_testdata();
		int          fd;
		int          n;
		int          g;
		string       line;
		string       name;
		logic [31:0] w [4];
		logic [31:0] a;
		logic [31:0] v;
		logic [31:0] m;
		int          pc_idx;
		pc_idx = 0;
		for (int i = 0; i < IMEM_WORDS; i++)
			imem[i] = 32'h0; // unknown opcode, no-op
		for (int i = 0; i < DMEM_WORDS; i++)
			dmem[i] = {i[15:0], ~i[15:0]};
		fd = $fopen("rv_core_testdata.txt", "r");
		if (fd == 0) begin
			$display("cannot open rv_core_testdata.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 1 && line[0] == "p") begin
					n = $sscanf(line, "p %h %h %h %h", w[0], w[1], w[2], w[3]);
					for (int i = 0; i < n; i++) begin
						imem[pc_idx] = w[i];
						pc_idx++;
					end
				end else if (n > 1 && line[0] == "d") begin
					n = $sscanf(line, "d %h %h", a, v);
					dmem[a[11:2]] = v;
				end else if (n > 1 && line[0] == "g") begin
					n = $sscanf(line, "g %s %h %h", name, a, v);
					grp_name.push_back(name);
					grp_lo.push_back(a);
					grp_hi.push_back(v);
					grp_fail.push_back(0);
				end else if (n > 1 && line[0] == "e") begin
					n = $sscanf(line, "e %h %h %h", a, v, m);
					g = 0;
					for (int i = grp_lo.size() - 1; i >= 0; i--)
						if (a >= grp_lo[i] && a <= grp_hi[i])
							g = i;
					exp_addr.push_back(a);
					exp_data.push_back(v);
					exp_mask.push_back(m[3:0]);
					exp_grp.push_back(g);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic check_val(input string name, input logic [31:0] expv,
		input logic [31:0] actv, input int g);
		if (actv !== expv) begin
			$display("MISMATCH at %0t: %s expected %h got %h", $time, name, expv, actv);
			errors++;
			grp_fail[g]++;
		end else begin
			passes++;
		end
	endtask

	// store monitor, sampled mid-cycle where DUT outputs are settled
	always @(negedge clk) begin
		if (!arst_n) begin
			if (dmem_we !== 1'b0) begin
				$display("dmem_we high during reset at %0t", $time);
				errors++;
			end
		end else begin
			live_cycles++;
			if (dmem_we) begin
				if (idx >= exp_addr.size()) begin
					$display("unexpected extra store to %h at %0t", dmem_addr, $time);
					errors++;
				end else begin
					if (idx == 0) begin
						check_val("imem_addr", RESET_PC, imem_addr, exp_grp[0]);
						if (live_cycles != 1) begin // RESET_PC runs in the first cycle
							$display("first store came %0d cycles after reset, not 1, at %0t",
								live_cycles, $time);
							errors++;
							grp_fail[exp_grp[0]]++;
						end
					end
					check_val("dmem_addr", exp_addr[idx], dmem_addr, exp_grp[idx]);
					check_val("dmem_wdata", exp_data[idx], dmem_wdata, exp_grp[idx]);
					check_val("dmem_wmask", {28'h0, exp_mask[idx]}, {28'h0, dmem_wmask},
						exp_grp[idx]);
					if (idx == exp_addr.size() - 1 || exp_grp[idx + 1] != exp_grp[idx])
						$display("test %s done, %0d errors", grp_name[exp_grp[idx]],
							grp_fail[exp_grp[idx]]);
					idx++;
				end
			end
		end
	end

	initial begin
		int cycles;
		idx         = 0;
		passes      = 0;
		errors      = 0;
		live_cycles = 0;
		cycles      = 0;
		load_testdata();
		while (idx < exp_addr.size() && cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		if (idx < exp_addr.size()) begin
			$display("timeout: store %0d to %h never appeared", idx, exp_addr[idx]);
			errors++;
		end else begin
			repeat (10) @(posedge clk); // catch stray stores in the final loop
		end
		$display("checks passed %0d, failed %0d", passes, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule
